// ==== Makefile ====
OBJ_DIR = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module cache_tb \
		--Mdir $(OBJ_DIR) -o Vcache_tb -f mini_cache.f

run: compile
	./$(OBJ_DIR)/Vcache_tb

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb;

    localparam int N_RANDOM = 400;
    localparam int N_REQ    = N_RANDOM + 8;

    logic clk = 1'b0;
    logic reset;
    logic core_req_valid, core_req_rw, core_req_ready;
    cache_pkg::word_addr_t core_req_addr;
    cache_pkg::byteen_t core_req_byteen;
    cache_pkg::word_t core_req_data, core_rsp_data;
    cache_pkg::core_id_t core_req_id, core_rsp_id;
    logic core_rsp_valid, core_rsp_ready;
    logic mem_req_valid, mem_req_rw, mem_req_ready;
    cache_pkg::line_addr_t mem_req_addr;
    cache_pkg::line_byteen_t mem_req_byteen;
    cache_pkg::line_t mem_req_data, mem_rsp_data;
    logic mem_rsp_valid, mem_rsp_ready;

    logic [31:0] lfsr = 32'h0bc542c3;
    cache_pkg::line_t mem [64];
    logic [15:0] id_busy = '0;
    int reads_pending = 0;
    int writes_pending = 0;

    cache_top #(.NUM_LINES(16)) dut0 (.*);

    always #50 clk = !clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////

    initial begin
        for (int l = 0; l < 64; l++) begin
            for (int w = 0; w < 4; w++) begin
                mem[l][w*32 +: 32] = 32'(l * 4 + w) ^ 32'h5a5a0000;
            end
        end
    end

    always begin : memory_model
        logic req_fire, rsp_fire, rw, fill_pending;
        cache_pkg::line_addr_t addr, fill_addr;
        cache_pkg::line_byteen_t be;
        cache_pkg::line_t data;
        logic [31:0] r;
        int delay;
        fill_pending = 1'b0;
        delay = 0;
        forever begin
            @(negedge clk);
            req_fire = mem_req_valid && mem_req_ready;
            rsp_fire = mem_rsp_valid && mem_rsp_ready;
            rw = mem_req_rw;
            addr = mem_req_addr;
            be = mem_req_byteen;
            data = mem_req_data;
            if (req_fire && rw) begin
                writes_pending--;
            end
            @(posedge clk);
            #5;
            if (req_fire && rw) begin
                for (int b = 0; b < 16; b++) begin
                    if (be[b]) begin
                        mem[addr[5:0]][b*8 +: 8] = data[b*8 +: 8];
                    end
                end
            end else if (req_fire) begin
                fill_pending = 1'b1;
                fill_addr = addr;
                r = take_bits(3);
                delay = int'(r);
            end
            if (rsp_fire) begin
                mem_rsp_valid = 1'b0;
            end
            if (fill_pending && delay == 0 && !mem_rsp_valid) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data = mem[fill_addr[5:0]];
                fill_pending = 1'b0;
            end else if (delay > 0) begin
                delay--;
            end
            mem_req_ready = (take_bits(2) != 0);
        end
    end

    ////////////////////////////////////////////////////////////
    // Core side
    ////////////////////////////////////////////////////////////

    always begin : response_sink
        @(negedge clk);
        if (core_rsp_valid && core_rsp_ready) begin
            reads_pending--;
            id_busy[core_rsp_id] = 1'b0;
        end
        @(posedge clk);
        #5;
        if (!reset) begin
            core_rsp_ready = (take_bits(2) != 0);
        end
    end

    task automatic send(input logic rw, input logic [7:0] addr, input cache_pkg::byteen_t be,
                        input cache_pkg::word_t data);
        int id;
        id = 0;
        // Read ids stay unique among pending reads
        while (!rw && id_busy == 16'hffff) begin
            @(posedge clk);
            #5;
        end
        if (!rw) begin
            while (id_busy[id]) id++;
            id_busy[id] = 1'b1;
        end
        core_req_valid = 1'b1;
        core_req_rw = rw;
        core_req_addr = 30'(addr);
        core_req_byteen = be;
        core_req_data = data;
        core_req_id = 4'(id);
        forever begin
            @(negedge clk);
            if (core_req_ready) break;
            @(posedge clk);
            #5;
        end
        if (rw) writes_pending++;
        else reads_pending++;
        @(posedge clk);
        #5;
        core_req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (reads_pending != 0 || writes_pending != 0) begin
            @(posedge clk);
        end
        #5;
    endtask

    always @(negedge clk) begin
        if (dut0.chk.err_count != 0) begin
            $display("Test FAILED");
            $fatal(1, "assertion failure in the cache checker");
        end
    end

    initial begin : watchdog
        #(N_REQ * 600 * 100);
        $display("Test FAILED");
        $fatal(1, "timeout with %0d reads and %0d writes pending", reads_pending, writes_pending);
    end

    initial begin : stimulus
        logic [31:0] op, addr, be, data;
        reset = 1'b1;
        core_req_valid = 1'b0;
        core_req_rw = 1'b0;
        core_req_addr = '0;
        core_req_byteen = '0;
        core_req_data = '0;
        core_req_id = '0;
        core_rsp_ready = 1'b1;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        repeat (8) @(posedge clk);
        #5;
        reset = 1'b0;

        // Directed: miss, hit, write hit, merged read, conflict, write miss
        send(1'b0, 8'h10, 4'h0, 32'h0);
        wait_idle();
        send(1'b0, 8'h11, 4'h0, 32'h0);
        wait_idle();
        send(1'b1, 8'h11, 4'b0101, 32'hdeadbeef);
        wait_idle();
        send(1'b0, 8'h11, 4'h0, 32'h0);
        send(1'b0, 8'h51, 4'h0, 32'h0);
        send(1'b0, 8'h12, 4'h0, 32'h0);
        send(1'b1, 8'h93, 4'b1111, 32'h12345678);
        send(1'b0, 8'h93, 4'h0, 32'h0);
        wait_idle();

        for (int n = 0; n < N_RANDOM; n++) begin
            op = take_bits(1);
            addr = take_bits(8);
            be = take_bits(4);
            data = take_bits(32);
            send(op[0], addr[7:0], be[3:0], data);
        end
        wait_idle();

        if (dut0.chk.err_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "checker reported errors");
        end
    end

endmodule

// ==== dv/cache_tb_sva.sv ====
`timescale 1ns/1ns

module cache_tb_sva #(
    parameter int NUM_LINES = 16
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        core_req_valid,
    input  logic                        core_req_rw,
    input  cache_pkg::word_addr_t       core_req_addr,
    input  cache_pkg::byteen_t          core_req_byteen,
    input  cache_pkg::word_t            core_req_data,
    input  cache_pkg::core_id_t         core_req_id,
    input  logic                        core_req_ready,
    input  logic                        core_rsp_valid,
    input  cache_pkg::word_t            core_rsp_data,
    input  cache_pkg::core_id_t         core_rsp_id,
    input  logic                        core_rsp_ready,
    input  logic                        mem_req_valid,
    input  logic                        mem_req_rw,
    input  cache_pkg::line_addr_t       mem_req_addr,
    input  cache_pkg::line_byteen_t     mem_req_byteen,
    input  cache_pkg::line_t            mem_req_data,
    input  logic                        mem_req_ready,
    input  logic                        mem_rsp_valid,
    input  logic                        mem_rsp_ready
);

    localparam int INDEX_BITS = $clog2(NUM_LINES);

    int unsigned                err_count = 0;
    cache_pkg::word_t           shadow    [256];
    cache_pkg::word_t           pend_data [16];
    logic [15:0]                pend_busy;
    logic                       hit_inflight;
    cache_pkg::core_id_t        hit_id;
    logic [NUM_LINES-1:0]       res_valid;
    cache_pkg::line_addr_t      res_line  [NUM_LINES];
    int                         in_flight;
    logic                       fill_pend;

    // Expected memory writes, oldest first
    cache_pkg::line_addr_t      wq_addr [4];
    cache_pkg::line_byteen_t    wq_be   [4];
    cache_pkg::line_t           wq_data [4];
    logic [1:0]                 wq_rd;
    logic [1:0]                 wq_wr;
    logic [2:0]                 wq_cnt;

    logic                       req_fire;
    logic                       rsp_fire;
    logic                       mem_rd_fire;
    logic                       mem_wr_fire;
    logic                       fill_fire;
    cache_pkg::line_addr_t      req_line;
    logic [INDEX_BITS-1:0]      req_index;
    cache_pkg::word_t           merged;
    cache_pkg::line_t           wr_mask;
    cache_pkg::line_byteen_t    exp_be;
    cache_pkg::line_t           exp_data;

    assign req_fire    = core_req_valid && core_req_ready;
    assign rsp_fire    = core_rsp_valid && core_rsp_ready;
    assign mem_rd_fire = mem_req_valid && mem_req_ready && !mem_req_rw;
    assign mem_wr_fire = mem_req_valid && mem_req_ready && mem_req_rw;
    assign fill_fire   = mem_rsp_valid && mem_rsp_ready;
    assign req_line    = core_req_addr[cache_pkg::WORD_ADDR_BITS-1:cache_pkg::WSEL_BITS];
    assign req_index   = req_line[INDEX_BITS-1:0];

    always_comb begin
        merged = shadow[core_req_addr[7:0]];
        for (int b = 0; b < 4; b++) begin
            if (core_req_byteen[b]) begin
                merged[b*8 +: 8] = core_req_data[b*8 +: 8];
            end
        end
        for (int b = 0; b < 16; b++) begin
            wr_mask[b*8 +: 8] = {8{mem_req_byteen[b]}};
        end
        // Request word repeated in every slot of the line
        for (int b = 0; b < 16; b++) begin
            exp_be[b]            = (b / 4 == int'(core_req_addr[1:0]))
                                   && core_req_byteen[b % 4];
            exp_data[b*8 +: 8]   = core_req_data[(b % 4)*8 +: 8];
        end
    end

    //////////////////////////////////////////////////////////
    // Reference state
    //////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_busy    <= '0;
            hit_inflight <= 1'b0;
            res_valid    <= '0;
            in_flight    <= 0;
            fill_pend    <= 1'b0;
            wq_rd        <= '0;
            wq_wr        <= '0;
            wq_cnt       <= '0;
            for (int i = 0; i < 256; i++) begin
                shadow[i] <= 32'(i) ^ 32'h5a5a0000;
            end
        end else begin
            in_flight <= in_flight + int'(req_fire) - int'(rsp_fire) - int'(mem_wr_fire);
            if (rsp_fire) begin
                pend_busy[core_rsp_id] <= 1'b0;
                if (core_rsp_id == hit_id) begin
                    hit_inflight <= 1'b0;
                end
            end
            if (req_fire && !core_req_rw) begin
                pend_busy[core_req_id] <= 1'b1;
                pend_data[core_req_id] <= shadow[core_req_addr[7:0]];
                // Only an empty pipeline makes residency certain
                if (in_flight == 0 && res_valid[req_index] && res_line[req_index] == req_line) begin
                    hit_inflight <= 1'b1;
                    hit_id       <= core_req_id;
                end
            end
            if (req_fire && core_req_rw) begin
                shadow[core_req_addr[7:0]] <= merged;
                wq_addr[wq_wr] <= req_line;
                wq_be[wq_wr]   <= exp_be;
                wq_data[wq_wr] <= exp_data;
                wq_wr <= wq_wr + 2'd1;
            end
            wq_cnt <= wq_cnt + 3'(req_fire && core_req_rw) - 3'(mem_wr_fire);
            if (mem_wr_fire) begin
                wq_rd <= wq_rd + 2'd1;
            end
            if (mem_rd_fire) begin
                res_valid[mem_req_addr[INDEX_BITS-1:0]] <= 1'b1;
                res_line[mem_req_addr[INDEX_BITS-1:0]]  <= mem_req_addr;
                fill_pend <= 1'b1;
            end else if (fill_fire) begin
                fill_pend <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////////////

    a_reset: assert property (@(posedge clk) $past(reset) |-> !core_rsp_valid && !mem_req_valid)
        else begin err_count++; $error("valid output high right after reset"); end

    a_rsp_id: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid |-> pend_busy[core_rsp_id])
        else begin err_count++; $error("response id has no pending read"); end

    a_rsp_data: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid |-> core_rsp_data == pend_data[core_rsp_id])
        else begin
            err_count++;
            $error("error read_data: expected %h actual %h", pend_data[core_rsp_id], core_rsp_data);
        end

    a_hit: assert property (@(posedge clk) disable iff (reset) mem_rd_fire |-> !hit_inflight)
        else begin err_count++; $error("line read issued for a resident line"); end

    a_fill_ready: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_ready == fill_pend)
        else begin err_count++; $error("memory response ready does not match an open line read"); end

    a_wr_extra: assert property (@(posedge clk) disable iff (reset) mem_wr_fire |-> wq_cnt != 0)
        else begin err_count++; $error("memory write without a core write"); end

    a_wr_addr: assert property (@(posedge clk) disable iff (reset)
        mem_wr_fire |-> mem_req_addr == wq_addr[wq_rd])
        else begin
            err_count++;
            $error("error write_addr: expected %h actual %h", wq_addr[wq_rd], mem_req_addr);
        end

    a_wr_be: assert property (@(posedge clk) disable iff (reset)
        mem_wr_fire |-> mem_req_byteen == wq_be[wq_rd])
        else begin
            err_count++;
            $error("error write_byteen: expected %h actual %h", wq_be[wq_rd], mem_req_byteen);
        end

    a_wr_data: assert property (@(posedge clk) disable iff (reset)
        mem_wr_fire |-> (mem_req_data & wr_mask) == (wq_data[wq_rd] & wr_mask))
        else begin
            err_count++;
            $error("error write_data: expected %h actual %h", wq_data[wq_rd] & wr_mask,
                   mem_req_data & wr_mask);
        end

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid && !core_rsp_ready
        |=> core_rsp_valid && $stable(core_rsp_data) && $stable(core_rsp_id))
        else begin err_count++; $error("core response changed under back-pressure"); end

    a_mem_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready
        |=> mem_req_valid && $stable(mem_req_rw) && $stable(mem_req_addr)
            && $stable(mem_req_byteen) && $stable(mem_req_data))
        else begin err_count++; $error("memory request changed under back-pressure"); end

endmodule

bind cache_top cache_tb_sva #(.NUM_LINES(NUM_LINES)) chk (.*);

// ==== logic/cache_bank_execute.sv ====
`timescale 1ns/1ns

module cache_bank_execute #(
    parameter int NUM_LINES = 16
) (
    input  logic                        clk,
    input  logic                        reset,

    cache_req_if.sink                   req,
    cache_rsp_if.source                 rsp,

    // Memory request
    output logic                        mem_req_valid,
    output logic                        mem_req_rw,
    output cache_pkg::line_addr_t       mem_req_addr,
    output cache_pkg::line_byteen_t     mem_req_byteen,
    output cache_pkg::line_t            mem_req_data,
    input  logic                        mem_req_ready,

    // Memory response
    input  logic                        mem_rsp_valid,
    input  cache_pkg::line_t            mem_rsp_data,
    output logic                        mem_rsp_ready
);

    localparam int INDEX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS   = cache_pkg::LINE_ADDR_BITS - INDEX_BITS;
    localparam int BYTE_BITS  = cache_pkg::WORD_BITS / cache_pkg::WORD_BYTES;
    localparam int LINE_BYTES = cache_pkg::LINE_WORDS * cache_pkg::WORD_BYTES;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL_REQ,
        S_FILL_WAIT,
        S_WRITE_REQ
    } state_t;

    state_t                 state;
    state_t                 state_n;

    logic [NUM_LINES-1:0]   valid_q;
    tag_t                   tag_q  [NUM_LINES];
    cache_pkg::line_t       data_q [NUM_LINES];

    index_t                 req_index;
    tag_t                   req_tag;
    logic                   hit;
    cache_pkg::line_t       hit_line;
    cache_pkg::line_t       merged_line;

    logic                   mem_req_fire;
    logic                   fill_fire;

    //////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////

    assign req_index = req.line_addr[INDEX_BITS-1:0];
    assign req_tag   = req.line_addr[cache_pkg::LINE_ADDR_BITS-1:INDEX_BITS];

    assign hit_line = data_q[req_index];
    assign hit      = valid_q[req_index] && (tag_q[req_index] == req_tag);

    //////////////////////////////////////////////////////////
    // Memory channel
    //////////////////////////////////////////////////////////

    // Payload comes straight from the held request, so it stays steady
    assign mem_req_valid  = (state == S_FILL_REQ) || (state == S_WRITE_REQ);
    assign mem_req_rw     = (state == S_WRITE_REQ);
    assign mem_req_addr   = req.line_addr;
    assign mem_req_byteen = cache_pkg::line_byteen_t'(req.byteen)
                            << (req.wsel * cache_pkg::WORD_BYTES);
    assign mem_req_data   = cache_pkg::line_t'(req.data)
                            << (req.wsel * cache_pkg::WORD_BITS);

    assign mem_req_fire  = mem_req_valid && mem_req_ready;
    assign mem_rsp_ready = (state == S_FILL_WAIT);
    assign fill_fire     = mem_rsp_valid && mem_rsp_ready;

    //////////////////////////////////////////////////////////
    // Core side
    //////////////////////////////////////////////////////////

    // Only read hits answer; a filled miss comes back here as a hit
    assign rsp.valid = (state == S_IDLE) && req.valid && !req.rw && hit;
    assign rsp.data  = hit_line[req.wsel*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS];
    assign rsp.id    = req.id;

    // Writes retire once memory has taken them
    assign req.ready = (rsp.valid && rsp.ready)
                    || ((state == S_WRITE_REQ) && mem_req_fire);

    // Write hit data, merged under the line byte enables
    always_comb begin
        merged_line = hit_line;
        for (int i = 0; i < LINE_BYTES; i++) begin
            if (mem_req_byteen[i]) begin
                merged_line[i*BYTE_BITS +: BYTE_BITS] = mem_req_data[i*BYTE_BITS +: BYTE_BITS];
            end
        end
    end

    //////////////////////////////////////////////////////////
    // Miss FSM
    //////////////////////////////////////////////////////////

    always_comb begin
        state_n = state;
        case (state)
            S_IDLE: begin
                if (req.valid) begin
                    if (req.rw) begin
                        state_n = S_WRITE_REQ;
                    end else if (!hit) begin
                        state_n = S_FILL_REQ;
                    end
                end
            end
            S_FILL_REQ: begin
                if (mem_req_ready) begin
                    state_n = S_FILL_WAIT;
                end
            end
            S_FILL_WAIT: begin
                if (mem_rsp_valid) begin
                    state_n = S_IDLE;
                end
            end
            S_WRITE_REQ: begin
                if (mem_req_ready) begin
                    state_n = S_IDLE;
                end
            end
            default: begin
                state_n = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            valid_q <= '0;
        end else begin
            state <= state_n;
            if (fill_fire) begin
                valid_q[req_index] <= 1'b1;
            end
        end
    end

    // Arrays; a write miss leaves them alone
    always_ff @(posedge clk) begin
        if (fill_fire) begin
            data_q[req_index] <= mem_rsp_data;
            tag_q[req_index]  <= req_tag;
        end else if (mem_req_fire && mem_req_rw && hit) begin
            data_q[req_index] <= merged_line;
        end
    end

endmodule

// ==== logic/cache_if.sv ====
`timescale 1ns/1ns

// Request from the decode register into the execute stage
interface cache_req_if;

    logic                   valid;
    logic                   rw;
    cache_pkg::line_addr_t  line_addr;
    cache_pkg::wsel_t       wsel;
    cache_pkg::byteen_t     byteen;
    cache_pkg::word_t       data;
    cache_pkg::core_id_t    id;
    logic                   ready;

    modport source (
        output valid, rw, line_addr, wsel, byteen, data, id,
        input  ready
    );

    modport sink (
        input  valid, rw, line_addr, wsel, byteen, data, id,
        output ready
    );

endinterface

// Read response from execute into the output register
interface cache_rsp_if;

    logic                   valid;
    cache_pkg::word_t       data;
    cache_pkg::core_id_t    id;
    logic                   ready;

    modport source (
        output valid, data, id,
        input  ready
    );

    modport sink (
        input  valid, data, id,
        output ready
    );

endinterface

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    //////////////////////////////////////////////////////////
    // Word geometry
    //////////////////////////////////////////////////////////

    localparam int WORD_BYTES = 4;
    localparam int WORD_BITS  = 32;

    // Core addresses count words, not bytes
    localparam int WORD_ADDR_BITS = 30;

    //////////////////////////////////////////////////////////
    // Line geometry
    //////////////////////////////////////////////////////////

    localparam int LINE_WORDS = 4;
    localparam int LINE_BITS  = LINE_WORDS * WORD_BITS;

    // Low word address bits pick the word inside a line
    localparam int WSEL_BITS      = 2;
    localparam int LINE_ADDR_BITS = WORD_ADDR_BITS - WSEL_BITS;

    // Tag the core attaches to each request
    localparam int CORE_ID_BITS = 4;

    //////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [WORD_BYTES-1:0]     byteen_t;
    typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;
    typedef logic [WSEL_BITS-1:0]      wsel_t;

    typedef logic [LINE_BITS-1:0]               line_t;
    typedef logic [LINE_WORDS*WORD_BYTES-1:0]   line_byteen_t;
    typedef logic [LINE_ADDR_BITS-1:0]          line_addr_t;

    typedef logic [CORE_ID_BITS-1:0] core_id_t;

endpackage

// ==== logic/cache_req_decode.sv ====
`timescale 1ns/1ns

module cache_req_decode (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    core_req_valid,
    input  logic                    core_req_rw,
    input  cache_pkg::word_addr_t   core_req_addr,
    input  cache_pkg::byteen_t      core_req_byteen,
    input  cache_pkg::word_t        core_req_data,
    input  cache_pkg::core_id_t     core_req_id,
    output logic                    core_req_ready,

    cache_req_if.source             req
);

    logic core_req_fire;

    // Open when empty or when execute takes the entry this cycle
    assign core_req_ready = !req.valid || req.ready;
    assign core_req_fire  = core_req_valid && core_req_ready;

    //////////////////////////////////////////////////////////
    // Entry valid
    //////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            req.valid <= 1'b0;
        end else if (core_req_ready) begin
            req.valid <= core_req_valid;
        end
    end

    //////////////////////////////////////////////////////////
    // Entry payload
    //////////////////////////////////////////////////////////

    // Split the word address on the way in
    always_ff @(posedge clk) begin
        if (core_req_fire) begin
            req.rw        <= core_req_rw;
            req.line_addr <= core_req_addr[cache_pkg::WORD_ADDR_BITS-1:cache_pkg::WSEL_BITS];
            req.wsel      <= core_req_addr[cache_pkg::WSEL_BITS-1:0];
            req.byteen    <= core_req_byteen;
            req.data      <= core_req_data;
            req.id        <= core_req_id;
        end
    end

endmodule

// ==== logic/cache_rsp_result.sv ====
`timescale 1ns/1ns

module cache_rsp_result (
    input  logic                    clk,
    input  logic                    reset,

    cache_rsp_if.sink               rsp,

    output logic                    core_rsp_valid,
    output cache_pkg::word_t        core_rsp_data,
    output cache_pkg::core_id_t     core_rsp_id,
    input  logic                    core_rsp_ready
);

    logic rsp_fire;

    // Takes a new entry in the cycle the old one drains
    assign rsp.ready = !core_rsp_valid || core_rsp_ready;
    assign rsp_fire  = rsp.valid && rsp.ready;

    //////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            core_rsp_valid <= 1'b0;
        end else if (rsp.ready) begin
            core_rsp_valid <= rsp.valid;
        end
    end

    // Held while the core stalls
    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            core_rsp_data <= rsp.data;
            core_rsp_id   <= rsp.id;
        end
    end

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/1ns

module cache_top #(
    parameter int NUM_LINES = 16
) (
    input  logic                        clk,
    input  logic                        reset,

    // Core request
    input  logic                        core_req_valid,
    input  logic                        core_req_rw,
    input  cache_pkg::word_addr_t       core_req_addr,
    input  cache_pkg::byteen_t          core_req_byteen,
    input  cache_pkg::word_t            core_req_data,
    input  cache_pkg::core_id_t         core_req_id,
    output logic                        core_req_ready,

    // Core response
    output logic                        core_rsp_valid,
    output cache_pkg::word_t            core_rsp_data,
    output cache_pkg::core_id_t         core_rsp_id,
    input  logic                        core_rsp_ready,

    // Memory request
    output logic                        mem_req_valid,
    output logic                        mem_req_rw,
    output cache_pkg::line_addr_t       mem_req_addr,
    output cache_pkg::line_byteen_t     mem_req_byteen,
    output cache_pkg::line_t            mem_req_data,
    input  logic                        mem_req_ready,

    // Memory response
    input  logic                        mem_rsp_valid,
    input  cache_pkg::line_t            mem_rsp_data,
    output logic                        mem_rsp_ready
);

    cache_req_if req_if ();
    cache_rsp_if rsp_if ();

    //////////////////////////////////////////////////////////
    // Decode, execute, result
    //////////////////////////////////////////////////////////

    cache_req_decode decode (
        .clk             (clk),
        .reset           (reset),
        .core_req_valid  (core_req_valid),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_id     (core_req_id),
        .core_req_ready  (core_req_ready),
        .req             (req_if.source)
    );

    cache_bank_execute #(
        .NUM_LINES (NUM_LINES)
    ) execute (
        .clk            (clk),
        .reset          (reset),
        .req            (req_if.sink),
        .rsp            (rsp_if.source),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_addr   (mem_req_addr),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    cache_rsp_result result (
        .clk            (clk),
        .reset          (reset),
        .rsp            (rsp_if.sink),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_data  (core_rsp_data),
        .core_rsp_id    (core_rsp_id),
        .core_rsp_ready (core_rsp_ready)
    );

endmodule

// ==== mini_cache.f ====
logic/cache_pkg.sv
logic/cache_if.sv
logic/cache_req_decode.sv
logic/cache_bank_execute.sv
logic/cache_rsp_result.sv
logic/cache_top.sv
dv/cache_tb_sva.sv
dv/cache_tb.sv
